// File: sprite_game_cfg.svh
`ifndef SPRITE_GAME_CFG_SVH
`define SPRITE_GAME_CFG_SVH

// screen geometry
`define SG_COORD_W       10
`define SG_X_MAX         10'd639          // last visible column
`define SG_Y_MAX         10'd479          // last visible row

// keyboard scan codes for movement
`define SG_KEY_LEFT      8'h04            // a
`define SG_KEY_RIGHT     8'h07            // d
`define SG_KEY_DOWN      8'h16            // s
`define SG_KEY_UP        8'h1A            // w

// player sprite
`define SG_PLAYER_STEP   10'd2            // pixels per frame
`define SG_PLAYER_SIZE   10'd30           // half of the box edge
`define SG_PLAYER_X0     10'd320
`define SG_PLAYER_Y0     10'd240

// room exits and where the player lands after crossing one
`define SG_EXIT_EAST_X   10'd590
`define SG_EXIT_WEST_X   10'd60
`define SG_EAST_ENTRY_X  10'd60
`define SG_EAST_ENTRY_Y  10'd200
`define SG_WEST_ENTRY_X  10'd560
`define SG_WEST_ENTRY_Y  10'd230

// backdrop codes per room
`define SG_COLOR_WEST    8'h0B
`define SG_COLOR_EAST    8'h0A

// enemies
`define SG_ENEMY_STEP    10'd1            // pixels per frame
`define SG_PARK_Y        10'd500          // below the screen, out of sight

`endif

// File: sprite_game_pkg.sv
`include "sprite_game_cfg.svh"

package sprite_game_pkg;

    // pixel coordinate on the 640x480 screen
    typedef logic [`SG_COORD_W-1:0] coord_t;

    // movement opcode from the keyboard
    typedef enum logic [2:0]
    {
        dir_none,
        dir_left,
        dir_right,
        dir_down,
        dir_up
    } dir_t;

    // which map is on screen
    typedef enum logic
    {
        room_west,
        room_east
    } room_t;

    // enemy patrol state, parked only leaves on reset
    typedef enum logic [1:0]
    {
        patrol_down,
        patrol_up,
        patrol_parked
    } patrol_t;

endpackage

// File: key_decoder.sv
`timescale 1ns/1ps
`include "sprite_game_cfg.svh"

module key_decoder
    import sprite_game_pkg::*;
(
    input  logic       Reset,      // frame clock, one rising edge per video frame
    input  logic       frame_clk,  // async reset, active high
    input  logic [7:0] keycode,    // held key, level
    input  logic       collision,  // level from the collision detector
    output dir_t       dir,
    output logic       blocked
);

    dir_t dir_next;

    // only the four movement keys mean anything
    always_comb
    begin
        case (keycode)
            `SG_KEY_LEFT:  dir_next = dir_left;
            `SG_KEY_RIGHT: dir_next = dir_right;
            `SG_KEY_DOWN:  dir_next = dir_down;
            `SG_KEY_UP:    dir_next = dir_up;
            default:       dir_next = dir_none;   // idle or unrelated key
        endcase
    end

    // opcode and collision go through the same register
    // so the motion stage sees both from the same frame
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            dir     <= dir_none;
            blocked <= 1'b0;
        end
        else
        begin
            dir     <= dir_next;
            blocked <= collision;
        end
    end

endmodule

// File: player_motion.sv
`timescale 1ns/1ps
`include "sprite_game_cfg.svh"

module player_motion
    import sprite_game_pkg::*;
(
    input  logic   Reset,      // frame clock
    input  logic   frame_clk,  // async reset, active high
    input  dir_t   dir,        // registered opcode from key_decoder
    input  logic   blocked,    // registered collision
    output coord_t player_x,   // sprite center
    output coord_t player_y,
    output room_t  room
);

    // two spare bits so the box edge can go below zero or past the limit
    localparam logic signed [11:0] STEP  = {2'b00, `SG_PLAYER_STEP};
    localparam logic signed [11:0] HALF  = {2'b00, `SG_PLAYER_SIZE};
    localparam logic signed [11:0] X_LIM = {2'b00, `SG_X_MAX};
    localparam logic signed [11:0] Y_LIM = {2'b00, `SG_Y_MAX};

    logic signed [11:0] step_x;
    logic signed [11:0] step_y;
    logic signed [11:0] cand_x;      // center one step away
    logic signed [11:0] cand_y;
    logic               off_screen;  // candidate box crosses a screen edge
    coord_t             kept_x;      // after collision and bound checks
    coord_t             kept_y;
    coord_t             x_next;
    coord_t             y_next;
    room_t              room_next;

    // one step per frame, screen y grows downward
    always_comb
    begin
        step_x = '0;
        step_y = '0;
        case (dir)
            dir_left:  step_x = -STEP;
            dir_right: step_x = STEP;
            dir_up:    step_y = -STEP;
            dir_down:  step_y = STEP;
            default:   ;                     // dir_none, stay put
        endcase
    end

    assign cand_x = $signed({2'b00, player_x}) + step_x;
    assign cand_y = $signed({2'b00, player_y}) + step_y;

    // whole box has to stay inside 0..limit on both axes
    assign off_screen = (cand_x - HALF < 0) || (cand_x + HALF > X_LIM) ||
                        (cand_y - HALF < 0) || (cand_y + HALF > Y_LIM);

    assign kept_x = (blocked || off_screen) ? player_x : cand_x[9:0];
    assign kept_y = (blocked || off_screen) ? player_y : cand_y[9:0];

    // room change looks at the position the move would leave us at
    always_comb
    begin
        room_next = room;
        x_next    = kept_x;
        y_next    = kept_y;
        if (room == room_west && kept_x > `SG_EXIT_EAST_X)
        begin
            room_next = room_east;           // walked off the east side
            x_next    = `SG_EAST_ENTRY_X;
            y_next    = `SG_EAST_ENTRY_Y;
        end
        else if (room == room_east && kept_x < `SG_EXIT_WEST_X)
        begin
            room_next = room_west;           // back through the west door
            x_next    = `SG_WEST_ENTRY_X;
            y_next    = `SG_WEST_ENTRY_Y;
        end
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            player_x <= `SG_PLAYER_X0;       // screen center
            player_y <= `SG_PLAYER_Y0;
            room     <= room_west;
        end
        else
        begin
            player_x <= x_next;
            player_y <= y_next;
            room     <= room_next;
        end
    end

endmodule

// File: enemy_patrol.sv
`timescale 1ns/1ps
`include "sprite_game_cfg.svh"

module enemy_patrol
    import sprite_game_pkg::*;
#(
    parameter coord_t X_POS   = 10'd350,   // fixed column of the patrol
    parameter coord_t Y_START = 10'd50,
    parameter coord_t Y_MIN   = 10'd0,     // top turn limit for the box edge
    parameter coord_t Y_MAX   = 10'd300,   // bottom turn limit for the box edge
    parameter coord_t SIZE    = 10'd30     // half of the box edge
)
(
    input  logic   Reset,      // frame clock
    input  logic   frame_clk,  // async reset, active high
    input  logic   kill,       // one-frame strobe
    output coord_t enemy_y,
    output logic   parked
);

    patrol_t state;
    logic    kill_q;           // strobe registered like the keyboard inputs
    logic    at_bottom;
    logic    at_top;

    // the patrol box has to start and run on screen
    if (({1'b0, X_POS} + SIZE > {1'b0, `SG_X_MAX}) || (X_POS < SIZE))
    begin : g_bad_column
        $error("enemy_patrol column %0d leaves the screen", X_POS);
    end

    if (({1'b0, Y_START} + SIZE > {1'b0, Y_MAX}) || ({1'b0, Y_START} < Y_MIN + SIZE))
    begin : g_bad_start
        $error("enemy_patrol start row %0d outside its patrol", Y_START);
    end

    // turn tests use the current y, 11 bits so nothing wraps
    assign at_bottom = ({1'b0, enemy_y} + SIZE) >= {1'b0, Y_MAX};
    assign at_top    = {1'b0, enemy_y} <= ({1'b0, Y_MIN} + SIZE);

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            kill_q  <= 1'b0;
            state   <= patrol_down;
            enemy_y <= Y_START;
        end
        else
        begin
            kill_q <= kill;
            if (kill_q)
            begin
                state   <= patrol_parked;    // dead for good
                enemy_y <= `SG_PARK_Y;
            end
            else
            begin
                case (state)
                    patrol_down:
                    begin
                        enemy_y <= enemy_y + `SG_ENEMY_STEP;
                        if (at_bottom)
                            state <= patrol_up;
                    end
                    patrol_up:
                    begin
                        enemy_y <= enemy_y - `SG_ENEMY_STEP;
                        if (at_top)
                            state <= patrol_down;
                    end
                    default: ;               // parked, hold the park row
                endcase
            end
        end
    end

    assign parked = (state == patrol_parked);

endmodule

// File: scene_out.sv
`timescale 1ns/1ps
`include "sprite_game_cfg.svh"

module scene_out
    import sprite_game_pkg::*;
#(
    parameter coord_t ENEMY0_X = 10'd350,
    parameter coord_t ENEMY1_X = 10'd510
)
(
    input  logic       Reset,        // frame clock
    input  logic       frame_clk,    // async reset, active high
    input  coord_t     motion_x,     // player position from player_motion
    input  coord_t     motion_y,
    input  room_t      motion_room,
    input  coord_t     patrol0_y,    // enemy rows from the two patrols
    input  coord_t     patrol1_y,
    input  logic [1:0] parked,
    output coord_t     player_x,
    output coord_t     player_y,
    output room_t      room,
    output logic [7:0] color_main,   // backdrop code
    output coord_t     enemy0_x,
    output coord_t     enemy0_y,
    output coord_t     enemy1_x,
    output coord_t     enemy1_y,
    output logic [1:0] enemy_visible,
    output logic [1:0] enemy_parked
);

    logic       in_east;
    logic [1:0] visible_next;

    assign in_east = (motion_room == room_east);

    // enemy 0 lives in the west room, enemy 1 in the east room
    assign visible_next[0] = ~parked[0] & ~in_east;
    assign visible_next[1] = ~parked[1] & in_east;

    // positions, loaded every frame
    always_ff @(posedge Reset)
    begin
        player_x <= motion_x;
        player_y <= motion_y;
        enemy0_y <= patrol0_y;
        enemy1_y <= patrol1_y;
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            room          <= room_west;
            color_main    <= `SG_COLOR_WEST;
            enemy_visible <= 2'b01;          // only the west enemy at start
            enemy_parked  <= 2'b00;
        end
        else
        begin
            room          <= motion_room;
            color_main    <= in_east ? `SG_COLOR_EAST : `SG_COLOR_WEST;
            enemy_visible <= visible_next;
            enemy_parked  <= parked;
        end
    end

    // enemies only patrol vertically
    assign enemy0_x = ENEMY0_X;
    assign enemy1_x = ENEMY1_X;

endmodule

// File: sprite_game_top.sv
`timescale 1ns/1ps

module sprite_game_top
    import sprite_game_pkg::*;
(
    input  logic       Reset,        // frame clock
    input  logic       frame_clk,    // async reset, active high
    input  logic [7:0] keycode,
    input  logic       collision,
    input  logic [1:0] enemy_kill,   // one-frame strobes per enemy
    output coord_t     player_x,
    output coord_t     player_y,
    output room_t      room,
    output logic [7:0] color_main,
    output coord_t     enemy0_x,
    output coord_t     enemy0_y,
    output coord_t     enemy1_x,
    output coord_t     enemy1_y,
    output logic [1:0] enemy_visible,
    output logic [1:0] enemy_parked
);

    localparam coord_t ENEMY0_X = 10'd350;
    localparam coord_t ENEMY1_X = 10'd510;

    dir_t       dir;
    logic       blocked;
    coord_t     motion_x;
    coord_t     motion_y;
    room_t      motion_room;
    coord_t     patrol0_y;
    coord_t     patrol1_y;
    logic [1:0] parked;

    key_decoder u_key_decoder (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .keycode   (keycode),
        .collision (collision),
        .dir       (dir),
        .blocked   (blocked)
    );

    player_motion u_player_motion (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .dir       (dir),
        .blocked   (blocked),
        .player_x  (motion_x),
        .player_y  (motion_y),
        .room      (motion_room)
    );

    // west room guard, long patrol
    enemy_patrol #(
        .X_POS   (ENEMY0_X),
        .Y_START (10'd50),
        .Y_MIN   (10'd0),
        .Y_MAX   (10'd300),
        .SIZE    (10'd30)
    ) u_enemy0 (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .kill      (enemy_kill[0]),
        .enemy_y   (patrol0_y),
        .parked    (parked[0])
    );

    // east room guard, short patrol
    enemy_patrol #(
        .X_POS   (ENEMY1_X),
        .Y_START (10'd195),
        .Y_MIN   (10'd150),
        .Y_MAX   (10'd270),
        .SIZE    (10'd28)
    ) u_enemy1 (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .kill      (enemy_kill[1]),
        .enemy_y   (patrol1_y),
        .parked    (parked[1])
    );

    scene_out #(
        .ENEMY0_X (ENEMY0_X),
        .ENEMY1_X (ENEMY1_X)
    ) u_scene_out (
        .Reset         (Reset),
        .frame_clk     (frame_clk),
        .motion_x      (motion_x),
        .motion_y      (motion_y),
        .motion_room   (motion_room),
        .patrol0_y     (patrol0_y),
        .patrol1_y     (patrol1_y),
        .parked        (parked),
        .player_x      (player_x),
        .player_y      (player_y),
        .room          (room),
        .color_main    (color_main),
        .enemy0_x      (enemy0_x),
        .enemy0_y      (enemy0_y),
        .enemy1_x      (enemy1_x),
        .enemy1_y      (enemy1_y),
        .enemy_visible (enemy_visible),
        .enemy_parked  (enemy_parked)
    );

endmodule

// File: sprite_game_checker.sv
`timescale 1ns/1ps
`include "sprite_game_cfg.svh"

module sprite_game_checker
    import sprite_game_pkg::*;
(
    input logic       Reset,             // frame clock
    input logic       frame_clk,         // async reset, active high
    input coord_t     player_x,
    input coord_t     player_y,
    input room_t      room,
    input logic [7:0] color_main,
    input logic [1:0] enemy_parked
);

    int fail_count = 0;                  // read back at the end of the run

    // distance of one coordinate between two frames, at most one step
    function automatic logic near(input coord_t a, input coord_t b);
        return ((a > b) ? (a - b) : (b - a)) <= `SG_PLAYER_STEP;
    endfunction

    // no teleport unless a door was crossed
    player_step: assert property (@(posedge Reset) disable iff (frame_clk)
        (room == $past(room)) |->
            (near(player_x, $past(player_x)) && near(player_y, $past(player_y))))
    else
    begin
        fail_count = fail_count + 1;
        $error("player moved more than one step without a room change");
    end

    backdrop_code: assert property (@(posedge Reset) disable iff (frame_clk)
        color_main == ((room == room_east) ? `SG_COLOR_EAST : `SG_COLOR_WEST))
    else
    begin
        fail_count = fail_count + 1;
        $error("backdrop code does not match the room");
    end

    // parked is sticky until reset
    parked_sticky: assert property (@(posedge Reset) disable iff (frame_clk)
        ($past(enemy_parked) & ~enemy_parked) == 2'b00)
    else
    begin
        fail_count = fail_count + 1;
        $error("an enemy left the parked state");
    end

endmodule

bind sprite_game_top sprite_game_checker u_sprite_game_checker (
    .Reset        (Reset),
    .frame_clk    (frame_clk),
    .player_x     (player_x),
    .player_y     (player_y),
    .room         (room),
    .color_main   (color_main),
    .enemy_parked (enemy_parked)
);

// File: tb_sprite_game.sv
`timescale 1ns/1ps
`include "sprite_game_cfg.svh"

module tb_sprite_game
    import sprite_game_pkg::*;
();

    localparam int NROWS = 13;
    localparam int DRAIN = 2;            // frames for the key to reach the outputs

    typedef struct packed
    {
        logic [7:0] key;                 // 00 picks a random idle key
        logic       coll;
        logic [1:0] kill;                // strobed on the first frame only
        logic [9:0] hold;
        coord_t     x;
        coord_t     y;
        room_t      room;
    } row_t;

    logic       Reset;                   // frame clock
    logic       frame_clk;               // reset
    logic [7:0] keycode;
    logic       collision;
    logic [1:0] enemy_kill;
    coord_t     player_x;
    coord_t     player_y;
    coord_t     enemy0_x;
    coord_t     enemy0_y;
    coord_t     enemy1_x;
    coord_t     enemy1_y;
    room_t      room;
    logic [7:0] color_main;
    logic [1:0] enemy_visible;
    logic [1:0] enemy_parked;

    row_t        rows [0:NROWS-1];
    int          cycles;
    int          cycle_limit;
    int          m_y [2];                // patrol rows inside the DUT
    patrol_t     m_st [2];
    logic        m_kq [2];               // registered kill strobe
    int          out_y [2];              // what scene_out shows
    logic [1:0]  out_pk;

    sprite_game_top u_sprite_game_top (
        .Reset         (Reset),
        .frame_clk     (frame_clk),
        .keycode       (keycode),
        .collision     (collision),
        .enemy_kill    (enemy_kill),
        .player_x      (player_x),
        .player_y      (player_y),
        .room          (room),
        .color_main    (color_main),
        .enemy0_x      (enemy0_x),
        .enemy0_y      (enemy0_y),
        .enemy1_x      (enemy1_x),
        .enemy1_y      (enemy1_y),
        .enemy_visible (enemy_visible),
        .enemy_parked  (enemy_parked)
    );

    initial
    begin
        Reset = 1'b0;
        forever #5 Reset = ~Reset;       // 10 ns frame
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_room(input string name, input room_t got, input room_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH time=%0t %s got=%s expected=%s", $time, name,
                     got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_code(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // any code outside the four movement keys
    function automatic logic [7:0] idle_key();
        logic [7:0] k;
        k = 8'($urandom);
        if (k == `SG_KEY_LEFT || k == `SG_KEY_RIGHT || k == `SG_KEY_DOWN || k == `SG_KEY_UP)
            k = 8'h00;
        return k;
    endfunction

    // bounce rule for one enemy; turn test sees the row before the move
    task automatic advance_enemy(input int i, input int lo, input int hi, input int size);
        out_y[i]  = m_y[i];
        out_pk[i] = (m_st[i] == patrol_parked);
        if (m_kq[i])
        begin
            m_st[i] = patrol_parked;
            m_y[i]  = 500;
        end
        else if (m_st[i] == patrol_down)
        begin
            if (m_y[i] + size >= hi)
                m_st[i] = patrol_up;
            m_y[i] = m_y[i] + 1;
        end
        else if (m_st[i] == patrol_up)
        begin
            if (m_y[i] - size <= lo)
                m_st[i] = patrol_down;
            m_y[i] = m_y[i] - 1;
        end
        m_kq[i] = enemy_kill[i];
    endtask

    // one frame, enemies checked every frame
    task automatic tick();
        @(negedge Reset);
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("timeout after %0d frames, the run did not finish", cycles);
            abort_run();
        end
        advance_enemy(0, 0, 300, 30);
        advance_enemy(1, 150, 270, 28);
        check_coord("enemy0_y", enemy0_y, coord_t'(out_y[0]));
        check_coord("enemy1_y", enemy1_y, coord_t'(out_y[1]));
        check_flags("enemy_parked", enemy_parked, out_pk);
    endtask

    task automatic fill_table();
        // key, collision, kill, hold, then x, y, room once the row is done
        rows[0]  = '{8'h00, 1'b0, 2'b00, 10'd3,   10'd320, 10'd240, room_west};
        rows[1]  = '{8'h2C, 1'b0, 2'b00, 10'd4,   10'd320, 10'd240, room_west};
        rows[2]  = '{`SG_KEY_LEFT,  1'b0, 2'b00, 10'd10,  10'd300, 10'd240, room_west};
        rows[3]  = '{`SG_KEY_RIGHT, 1'b0, 2'b00, 10'd10,  10'd320, 10'd240, room_west};
        rows[4]  = '{`SG_KEY_UP,    1'b0, 2'b00, 10'd5,   10'd320, 10'd230, room_west};
        rows[5]  = '{`SG_KEY_DOWN,  1'b0, 2'b00, 10'd5,   10'd320, 10'd240, room_west};
        rows[6]  = '{`SG_KEY_LEFT,  1'b1, 2'b00, 10'd6,   10'd320, 10'd240, room_west};
        rows[7]  = '{`SG_KEY_UP,    1'b0, 2'b00, 10'd110, 10'd320, 10'd30,  room_west};  // top edge
        rows[8]  = '{`SG_KEY_DOWN,  1'b0, 2'b00, 10'd5,   10'd320, 10'd40,  room_west};
        rows[9]  = '{`SG_KEY_RIGHT, 1'b0, 2'b00, 10'd136, 10'd60,  10'd200, room_east};  // 592 > 590
        rows[10] = '{8'h00, 1'b0, 2'b10, 10'd4,   10'd60,  10'd200, room_east};  // east guard hidden
        rows[11] = '{`SG_KEY_LEFT,  1'b0, 2'b00, 10'd1,   10'd560, 10'd230, room_west};  // 58 < 60
        rows[12] = '{8'h00, 1'b0, 2'b01, 10'd4,   10'd560, 10'd230, room_west};
    endtask

    initial
    begin
        frame_clk  = 1'b1;
        keycode    = 8'h00;
        collision  = 1'b0;
        enemy_kill = 2'b00;
        cycles     = 0;
        void'($urandom(78612));
        fill_table();
        cycle_limit = 50;
        for (int r = 0; r < NROWS; r++)
            cycle_limit += rows[r].hold + DRAIN;
        m_y   = '{50, 195};              // start rows
        m_st  = '{patrol_down, patrol_down};
        m_kq  = '{1'b0, 1'b0};
        out_y = '{50, 195};
        out_pk = 2'b00;

        repeat (5) @(negedge Reset);
        frame_clk = 1'b0;

        check_coord("player_x", player_x, 10'd320);
        check_coord("player_y", player_y, 10'd240);
        check_room("room", room, room_west);
        check_code("color_main", color_main, `SG_COLOR_WEST);
        check_flags("enemy_visible", enemy_visible, 2'b01);
        check_flags("enemy_parked", enemy_parked, 2'b00);
        check_coord("enemy0_x", enemy0_x, 10'd350);
        check_coord("enemy1_x", enemy1_x, 10'd510);

        for (int r = 0; r < NROWS; r++)
        begin
            keycode    = (rows[r].key == 8'h00) ? idle_key() : rows[r].key;
            collision  = rows[r].coll;
            enemy_kill = rows[r].kill;
            for (int c = 0; c < rows[r].hold; c++)
            begin
                tick();
                enemy_kill = 2'b00;      // kill is a single frame
            end
            keycode   = idle_key();      // let the pipeline settle
            collision = 1'b0;
            repeat (DRAIN) tick();
            check_coord("player_x", player_x, rows[r].x);
            check_coord("player_y", player_y, rows[r].y);
            check_room("room", room, rows[r].room);
            check_code("color_main", color_main,
                       (rows[r].room == room_east) ? `SG_COLOR_EAST : `SG_COLOR_WEST);
            check_flags("enemy_visible", enemy_visible,
                        {~out_pk[1] & (rows[r].room == room_east),
                         ~out_pk[0] & (rows[r].room == room_west)});
        end

        if (u_sprite_game_top.u_sprite_game_checker.fail_count != 0)
        begin
            $display("%0d assertion failures in the bound checker",
                     u_sprite_game_top.u_sprite_game_checker.fail_count);
            abort_run();
        end
        else
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: sprite_game.f
+incdir+.
sprite_game_pkg.sv
key_decoder.sv
player_motion.sv
enemy_patrol.sv
scene_out.sv
sprite_game_top.sv
sprite_game_checker.sv
tb_sprite_game.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f sprite_game.f --top-module tb_sprite_game -o tb_sprite_game; then
    echo "build failed"
    exit 1
fi

# keep running past an assertion so the testbench can report it
if ! ./obj_dir/tb_sprite_game +verilator+error+limit+1000 > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q -F "*** TEST PASSED ***" sim.log; then
    exit 0
else
    echo "pass line not found in sim.log"
    exit 1
fi
